//--- verilog.f
design/l15_bridge_pkg.sv
design/store_align.sv
design/l15_req_encoder.sv
design/thread_id_pool.sv
design/l15_req_fsm.sv
design/l15_resp_decoder.sv
design/hpdc_l15_bridge.sv
testbench/tb_clock_gen.sv
testbench/tb_hpdc_l15_bridge.sv

//--- run_verilator.sh
#!/bin/sh
# Builds the bridge testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_hpdc_l15_bridge -o sim_bridge
./obj_dir/sim_bridge > sim.log 2>&1
cat sim.log
if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- testbench/tb_hpdc_l15_bridge.sv
// Table-driven test of the cache to L1.5 bridge against a cycle-exact L1.5 responder
// Assumes 128-bit data, four thread ids and byte swapping enabled
`timescale 1ns/100ps
module tb_hpdc_l15_bridge;

    localparam int unsigned MemDataWidth   = 128;
    localparam int unsigned TidWidth       = 2;
    localparam int unsigned IdWidth        = 4;
    localparam int unsigned PidWidth       = 3;
    localparam int          NumRows        = 15;
    localparam int          ClkPeriodNs    = 40;
    localparam int          WatchdogCycles = NumRows * 60;

    localparam logic [63:0] WD    = 64'h0706_0504_0302_0100;  // Byte i holds i
    localparam logic [63:0] WD_SW = 64'h0001_0203_0405_0607;  // Same, byte-swapped

    typedef struct {
        l15_bridge_pkg::req_kind_e     kind;
        logic [39:0]                   addr;
        logic [2:0]                    size;
        logic                          cacheable;
        logic [63:0]                   wdata;
        logic [15:0]                   be;
        logic [IdWidth-1:0]            id;
        logic [PidWidth-1:0]           pid;
        int                            hack_dly;   // Valid cycles before header ack
        int                            ack_dly;    // Cycles from header ack to ack
        int                            rtrn_mode;  // 0 at once, 1 held, 2 then flush held
        l15_bridge_pkg::l15_rtrntype_e rtype;
        logic [63:0]                   rdata;
        int                            rdy_dly;
        logic [4:0]                    exp_rqtype;
        logic                          exp_nc;
        logic [2:0]                    exp_size;
        logic [39:0]                   exp_addr;
        logic [63:0]                   exp_data;
        logic [7:0]                    exp_be;
    } row_t;

    logic clk_i;
    logic rst_ni;

    logic                                req_valid_i;
    l15_bridge_pkg::req_kind_e           req_kind_i;
    logic [l15_bridge_pkg::PA_WIDTH-1:0] req_addr_i;
    l15_bridge_pkg::req_size_t           req_size_i;
    logic                                req_cacheable_i;
    logic [MemDataWidth-1:0]             req_wdata_i;
    logic [MemDataWidth/8-1:0]           req_be_i;
    logic [IdWidth-1:0]                  req_id_i;
    logic [PidWidth-1:0]                 req_pid_i;
    logic                                req_ready_o;
    logic                                l15_val_o;
    l15_bridge_pkg::l15_rqtype_e         l15_rqtype_o;
    logic                                l15_nc_o;
    logic [2:0]                          l15_size_o;
    logic [TidWidth-1:0]                 l15_threadid_o;
    logic [l15_bridge_pkg::PA_WIDTH-1:0] l15_address_o;
    logic [63:0]                         l15_data_o;
    logic [7:0]                          l15_be_o;
    logic                                l15_header_ack_i;
    logic                                l15_ack_i;
    logic                                l15_rtrn_val_i;
    l15_bridge_pkg::l15_rtrntype_e       l15_rtrn_type_i;
    logic [TidWidth-1:0]                 l15_rtrn_threadid_i;
    logic [MemDataWidth-1:0]             l15_rtrn_data_i;
    logic                                l15_req_ack_o;
    logic                                resp_valid_o;
    logic [IdWidth-1:0]                  resp_id_o;
    logic [PidWidth-1:0]                 resp_pid_o;
    logic [MemDataWidth-1:0]             resp_data_o;
    logic                                resp_error_o;
    logic                                resp_ready_i;

    row_t                rows [NumRows];
    logic [TidWidth-1:0] free_tids [$];  // Expected pool contents, oldest first
    int                  held_rows [$];
    logic [TidWidth-1:0] held_tids [$];
    int                  num_checks;
    int                  num_errors;

    tb_clock_gen #(
        .HalfPeriodNs (ClkPeriodNs / 2),
        .RstCycles    (4)
    ) i_tb_clock_gen (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    hpdc_l15_bridge #(
        .MemDataWidth (MemDataWidth),
        .TidWidth     (TidWidth),
        .IdWidth      (IdWidth),
        .PidWidth     (PidWidth)
    ) i_hpdc_l15_bridge (
        .*
    );

    function automatic logic [63:0] reverse_bytes(input logic [63:0] d);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[56-8*i +: 8];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        num_checks++;
        assert (expected === actual) else begin
            num_errors++;
            $display("mismatch %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // L1.5 request fields, held for the whole handshake
    task automatic check_l15_fields(input int r, input logic [TidWidth-1:0] tid);
        check_value("l15_rqtype_o", rows[r].exp_rqtype, l15_rqtype_o);
        check_value("l15_nc_o", rows[r].exp_nc, l15_nc_o);
        check_value("l15_size_o", rows[r].exp_size, l15_size_o);
        check_value("l15_threadid_o", tid, l15_threadid_o);
        check_value("l15_address_o", rows[r].exp_addr, l15_address_o);
        check_value("l15_data_o", rows[r].exp_data, l15_data_o);
        check_value("l15_be_o", rows[r].exp_be, l15_be_o);
    endtask

    // Starts and ends just after a falling edge
    task automatic send_return(input int r, input logic [TidWidth-1:0] tid);
        logic [63:0] hi;
        hi                  = {$urandom, $urandom};
        l15_rtrn_val_i      = 1'b1;
        l15_rtrn_type_i     = rows[r].rtype;
        l15_rtrn_threadid_i = tid;
        l15_rtrn_data_i     = {hi, rows[r].rdata};
        for (int c = 0; c <= rows[r].rdy_dly; c++) begin
            resp_ready_i = (c == rows[r].rdy_dly);
            #1;
            check_value("resp_valid_o", 1'b1, resp_valid_o);
            check_value("l15_req_ack_o", resp_ready_i, l15_req_ack_o);
            check_value("resp_id_o", rows[r].id, resp_id_o);
            check_value("resp_pid_o", rows[r].pid, resp_pid_o);
            check_value("resp_error_o", rows[r].rtype == l15_bridge_pkg::L15_ERR_RET,
                        resp_error_o);
            check_value("resp_data_o[63:0]", reverse_bytes(rows[r].rdata), resp_data_o[63:0]);
            check_value("resp_data_o[127:64]", reverse_bytes(hi), resp_data_o[127:64]);
            @(negedge clk_i);
        end
        l15_rtrn_val_i = 1'b0;
        resp_ready_i   = 1'b0;
        free_tids.push_back(tid);  // Usable from this cycle on
    endtask

    task automatic run_request(input int r);
        int                  hd;
        int                  ad;
        logic [TidWidth-1:0] tid;
        hd              = rows[r].hack_dly;
        ad              = rows[r].ack_dly;
        req_valid_i     = 1'b1;
        req_kind_i      = rows[r].kind;
        req_addr_i      = rows[r].addr;
        req_size_i      = rows[r].size;
        req_cacheable_i = rows[r].cacheable;
        req_wdata_i     = {$urandom, $urandom, rows[r].wdata};  // Random upper dword
        req_be_i        = rows[r].be;
        req_id_i        = rows[r].id;
        req_pid_i       = rows[r].pid;
        if (free_tids.size() == 0) begin
            // No id left, request must wait for a return
            repeat (3) begin
                #1;
                check_value("l15_val_o", 1'b0, l15_val_o);
                check_value("req_ready_o", 1'b0, req_ready_o);
                @(negedge clk_i);
            end
            send_return(held_rows.pop_back(), held_tids.pop_back());
        end
        tid = free_tids.pop_front();
        for (int c = 0; c <= hd + ad; c++) begin
            l15_header_ack_i = (c == hd);
            l15_ack_i        = (c == hd + ad);
            #1;
            check_value("l15_val_o", c <= hd, l15_val_o);
            check_value("req_ready_o", c == hd + ad, req_ready_o);
            check_l15_fields(r, tid);
            @(negedge clk_i);
        end
        req_valid_i      = 1'b0;
        l15_header_ack_i = 1'b0;
        l15_ack_i        = 1'b0;
        case (rows[r].rtrn_mode)
            0: send_return(r, tid);
            1: begin
                held_rows.push_back(r);
                held_tids.push_back(tid);
            end
            default: begin
                send_return(r, tid);
                while (held_rows.size() != 0) begin  // Newest first, out of order
                    send_return(held_rows.pop_back(), held_tids.pop_back());
                end
            end
        endcase
    endtask

    initial begin
        void'($urandom(32'hdc25));
        num_checks          = 0;
        num_errors          = 0;
        req_valid_i         = 1'b0;
        req_kind_i          = l15_bridge_pkg::REQ_LOAD;
        req_addr_i          = '0;
        req_size_i          = '0;
        req_cacheable_i     = 1'b0;
        req_wdata_i         = '0;
        req_be_i            = '0;
        req_id_i            = '0;
        req_pid_i           = '0;
        l15_header_ack_i    = 1'b0;
        l15_ack_i           = 1'b0;
        l15_rtrn_val_i      = 1'b0;
        l15_rtrn_type_i     = l15_bridge_pkg::L15_LOAD_RET;
        l15_rtrn_threadid_i = '0;
        l15_rtrn_data_i     = '0;
        resp_ready_i        = 1'b0;
        rows = '{
            // Four held loads and fills, the fifth finds the pool empty
            '{l15_bridge_pkg::REQ_LOAD, 40'h4008, 3'd3, 1'b1, WD, 16'h0000, 4'h1, 3'd0,
              0, 0, 1, l15_bridge_pkg::L15_LOAD_RET, 64'h1122_3344_5566_7788, 0,
              5'h00, 1'b0, 3'd4, 40'h4008, WD_SW, 8'h00},
            '{l15_bridge_pkg::REQ_UNC_LOAD, 40'h4010, 3'd2, 1'b0, WD, 16'h0000, 4'h2, 3'd1,
              1, 2, 1, l15_bridge_pkg::L15_LOAD_RET, 64'h2233_4455_6677_8899, 2,
              5'h00, 1'b1, 3'd3, 40'h4010, WD_SW, 8'h00},
            '{l15_bridge_pkg::REQ_IFILL, 40'h5000, 3'd0, 1'b1, WD, 16'h0000, 4'h3, 3'd2,
              2, 0, 1, l15_bridge_pkg::L15_IFILL_RET, 64'h3344_5566_7788_99aa, 1,
              5'h10, 1'b0, 3'd6, 40'h5000, WD_SW, 8'h00},
            '{l15_bridge_pkg::REQ_IFILL, 40'h5020, 3'd0, 1'b0, WD, 16'h0000, 4'h4, 3'd3,
              0, 3, 1, l15_bridge_pkg::L15_ERR_RET, 64'h4455_6677_8899_aabb, 0,
              5'h10, 1'b1, 3'd3, 40'h5020, WD_SW, 8'h00},
            '{l15_bridge_pkg::REQ_LOAD, 40'h4040, 3'd2, 1'b1, WD, 16'h0000, 4'h5, 3'd4,
              3, 0, 2, l15_bridge_pkg::L15_LOAD_RET, 64'h5566_7788_99aa_bbcc, 3,
              5'h00, 1'b0, 3'd3, 40'h4040, WD_SW, 8'h00},
            // Cacheable stores, aligned from the byte mask
            '{l15_bridge_pkg::REQ_STORE, 40'h1000, 3'd0, 1'b1, WD, 16'h0008, 4'h6, 3'd5,
              0, 1, 0, l15_bridge_pkg::L15_STORE_ACK, 64'h6677_8899_aabb_ccdd, 0,
              5'h01, 1'b0, 3'd1, 40'h1003, WD_SW, 8'h10},
            '{l15_bridge_pkg::REQ_STORE, 40'h1000, 3'd1, 1'b1, WD, 16'h0030, 4'h7, 3'd6,
              1, 0, 1, l15_bridge_pkg::L15_STORE_ACK, 64'h7788_99aa_bbcc_ddee, 1,
              5'h01, 1'b0, 3'd2, 40'h1004, WD_SW, 8'h0c},
            '{l15_bridge_pkg::REQ_STORE, 40'h1007, 3'd2, 1'b1, WD, 16'h000f, 4'h8, 3'd7,
              2, 2, 2, l15_bridge_pkg::L15_STORE_ACK, 64'h8899_aabb_ccdd_eeff, 0,
              5'h01, 1'b0, 3'd3, 40'h1000, WD_SW, 8'hf0},
            '{l15_bridge_pkg::REQ_STORE, 40'h1008, 3'd3, 1'b1, WD, 16'h00ff, 4'h9, 3'd0,
              3, 1, 0, l15_bridge_pkg::L15_STORE_ACK, 64'h99aa_bbcc_ddee_ff00, 2,
              5'h01, 1'b0, 3'd4, 40'h1008, WD_SW, 8'hff},
            '{l15_bridge_pkg::REQ_STORE, 40'h1005, 3'd3, 1'b1, WD, 16'h0b00, 4'ha, 3'd1,
              1, 3, 0, l15_bridge_pkg::L15_ERR_RET, 64'haabb_ccdd_eeff_0011, 0,
              5'h01, 1'b0, 3'd4, 40'h1005, WD_SW, 8'hd0},
            '{l15_bridge_pkg::REQ_STORE, 40'h2000, 3'd2, 1'b1, WD, 16'hf000, 4'hb, 3'd2,
              0, 2, 1, l15_bridge_pkg::L15_STORE_ACK, 64'hbbcc_ddee_ff00_1122, 0,
              5'h01, 1'b0, 3'd3, 40'h2004, WD_SW, 8'h0f},
            // Uncached stores, data replicated from the address offset
            '{l15_bridge_pkg::REQ_UNC_STORE, 40'h3005, 3'd0, 1'b0, WD, 16'h0020, 4'hc, 3'd3,
              2, 1, 1, l15_bridge_pkg::L15_STORE_ACK, 64'hccdd_eeff_0011_2233, 1,
              5'h01, 1'b1, 3'd1, 40'h3005, 64'h0505_0505_0505_0505, 8'h04},
            '{l15_bridge_pkg::REQ_UNC_STORE, 40'h3006, 3'd1, 1'b0, WD, 16'h00c0, 4'hd, 3'd4,
              3, 3, 1, l15_bridge_pkg::L15_STORE_ACK, 64'hddee_ff00_1122_3344, 0,
              5'h01, 1'b1, 3'd2, 40'h3006, 64'h0607_0607_0607_0607, 8'h03},
            '{l15_bridge_pkg::REQ_UNC_STORE, 40'h3000, 3'd2, 1'b0, WD, 16'h000f, 4'he, 3'd5,
              1, 1, 2, l15_bridge_pkg::L15_STORE_ACK, 64'heeff_0011_2233_4455, 3,
              5'h01, 1'b1, 3'd3, 40'h3000, 64'h0001_0203_0001_0203, 8'hf0},
            '{l15_bridge_pkg::REQ_UNC_STORE, 40'h3008, 3'd3, 1'b0, WD, 16'h00ff, 4'hf, 3'd6,
              0, 0, 0, l15_bridge_pkg::L15_STORE_ACK, 64'hff00_1122_3344_5566, 1,
              5'h01, 1'b1, 3'd4, 40'h3008, WD_SW, 8'hff}
        };
        for (int i = 0; i < (1 << TidWidth); i++) begin
            free_tids.push_back(TidWidth'(i));
        end
        @(posedge rst_ni);
        @(negedge clk_i);
        #1;
        check_value("req_ready_o", 1'b0, req_ready_o);
        check_value("l15_val_o", 1'b0, l15_val_o);
        check_value("resp_valid_o", 1'b0, resp_valid_o);
        check_value("l15_req_ack_o", 1'b0, l15_req_ack_o);
        @(negedge clk_i);
        for (int r = 0; r < NumRows; r++) begin
            run_request(r);
        end
        $display("Checks run: %0d, mismatches: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriodNs);
        $display("Watchdog expired after %0d cycles, the test did not complete", WatchdogCycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock and an active-low reset held for the first cycles
// Reset is released on a falling edge
`timescale 1ns/100ps
module tb_clock_gen #(
    parameter int unsigned HalfPeriodNs = 20,
    parameter int unsigned RstCycles    = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HalfPeriodNs) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RstCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- design/hpdc_l15_bridge.sv
// Data cache memory port to L1.5 bridge, up to 2**TidWidth requests in flight
// Cache must hold request fields while req_valid_i is high
`timescale 1ns/100ps
module hpdc_l15_bridge #(
    parameter int unsigned MemDataWidth   = 128,
    parameter int unsigned TidWidth       = 2,
    parameter int unsigned IdWidth        = 4,
    parameter int unsigned PidWidth       = 3,
    parameter bit          SwapEndianness = 1,
    parameter logic [2:0]  IfillUncSize   = 3'd3
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    // Cache request
    input  logic                                req_valid_i,
    input  l15_bridge_pkg::req_kind_e           req_kind_i,
    input  logic [l15_bridge_pkg::PA_WIDTH-1:0] req_addr_i,
    input  l15_bridge_pkg::req_size_t           req_size_i,
    input  logic                                req_cacheable_i,
    input  logic [MemDataWidth-1:0]             req_wdata_i,
    input  logic [MemDataWidth/8-1:0]           req_be_i,
    input  logic [IdWidth-1:0]                  req_id_i,
    input  logic [PidWidth-1:0]                 req_pid_i,
    output logic                                req_ready_o,
    // L1.5 request
    output logic                                l15_val_o,
    output l15_bridge_pkg::l15_rqtype_e         l15_rqtype_o,
    output logic                                l15_nc_o,
    output logic [2:0]                          l15_size_o,
    output logic [TidWidth-1:0]                 l15_threadid_o,
    output logic [l15_bridge_pkg::PA_WIDTH-1:0] l15_address_o,
    output logic [63:0]                         l15_data_o,
    output logic [7:0]                          l15_be_o,
    input  logic                                l15_header_ack_i,
    input  logic                                l15_ack_i,
    // L1.5 return
    input  logic                                l15_rtrn_val_i,
    input  l15_bridge_pkg::l15_rtrntype_e       l15_rtrn_type_i,
    input  logic [TidWidth-1:0]                 l15_rtrn_threadid_i,
    input  logic [MemDataWidth-1:0]             l15_rtrn_data_i,
    output logic                                l15_req_ack_o,
    // Cache response
    output logic                                resp_valid_o,
    output logic [IdWidth-1:0]                  resp_id_o,
    output logic [PidWidth-1:0]                 resp_pid_o,
    output logic [MemDataWidth-1:0]             resp_data_o,
    output logic                                resp_error_o,
    input  logic                                resp_ready_i
);

    logic                tid_avail;
    logic                free_tid;
    logic [IdWidth-1:0]  lookup_id;
    logic [PidWidth-1:0] lookup_pid;

    l15_req_encoder #(
        .MemDataWidth   (MemDataWidth),
        .SwapEndianness (SwapEndianness),
        .IfillUncSize   (IfillUncSize)
    ) i_l15_req_encoder (
        .kind_i      (req_kind_i),
        .addr_i      (req_addr_i),
        .size_i      (req_size_i),
        .cacheable_i (req_cacheable_i),
        .wdata_i     (req_wdata_i),
        .be_i        (req_be_i),
        .rqtype_o    (l15_rqtype_o),
        .nc_o        (l15_nc_o),
        .size_o      (l15_size_o),
        .address_o   (l15_address_o),
        .data_o      (l15_data_o),
        .l15_be_o    (l15_be_o)
    );

    // Granted on accept, returned when the response is taken
    thread_id_pool #(
        .TidWidth (TidWidth)
    ) i_thread_id_pool (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .push_i     (free_tid),
        .push_tid_i (l15_rtrn_threadid_i),
        .pop_i      (req_ready_o),
        .avail_o    (tid_avail),
        .tid_o      (l15_threadid_o)
    );

    l15_req_fsm #(
        .TidWidth (TidWidth),
        .IdWidth  (IdWidth),
        .PidWidth (PidWidth)
    ) i_l15_req_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_id_i     (req_id_i),
        .req_pid_i    (req_pid_i),
        .tid_avail_i  (tid_avail),
        .tid_i        (l15_threadid_o),
        .header_ack_i (l15_header_ack_i),
        .ack_i        (l15_ack_i),
        .l15_val_o    (l15_val_o),
        .req_ready_o  (req_ready_o),
        .lookup_tid_i (l15_rtrn_threadid_i),
        .lookup_id_o  (lookup_id),
        .lookup_pid_o (lookup_pid)
    );

    l15_resp_decoder #(
        .MemDataWidth   (MemDataWidth),
        .SwapEndianness (SwapEndianness),
        .IdWidth        (IdWidth),
        .PidWidth       (PidWidth)
    ) i_l15_resp_decoder (
        .rtrn_val_i   (l15_rtrn_val_i),
        .rtrn_type_i  (l15_rtrn_type_i),
        .rtrn_data_i  (l15_rtrn_data_i),
        .lookup_id_i  (lookup_id),
        .lookup_pid_i (lookup_pid),
        .resp_ready_i (resp_ready_i),
        .resp_valid_o (resp_valid_o),
        .resp_id_o    (resp_id_o),
        .resp_pid_o   (resp_pid_o),
        .resp_data_o  (resp_data_o),
        .resp_error_o (resp_error_o),
        .rtrn_ack_o   (l15_req_ack_o),
        .free_tid_o   (free_tid)
    );

endmodule

//--- design/l15_resp_decoder.sv
// L1.5 return to cache response, combinational in the return cycle
// Return is acked only when the cache can take the response
`timescale 1ns/100ps
module l15_resp_decoder #(
    parameter int unsigned MemDataWidth   = 128,
    parameter bit          SwapEndianness = 1,
    parameter int unsigned IdWidth        = 4,
    parameter int unsigned PidWidth       = 3
) (
    input  logic                          rtrn_val_i,
    input  l15_bridge_pkg::l15_rtrntype_e rtrn_type_i,
    input  logic [MemDataWidth-1:0]       rtrn_data_i,
    input  logic [IdWidth-1:0]            lookup_id_i,
    input  logic [PidWidth-1:0]           lookup_pid_i,
    input  logic                          resp_ready_i,
    output logic                          resp_valid_o,
    output logic [IdWidth-1:0]            resp_id_o,
    output logic [PidWidth-1:0]           resp_pid_o,
    output logic [MemDataWidth-1:0]       resp_data_o,
    output logic                          resp_error_o,
    output logic                          rtrn_ack_o,
    output logic                          free_tid_o
);

    localparam int unsigned DwordWidth = l15_bridge_pkg::DWORD_BYTES * 8;
    localparam int unsigned NumDwords  = MemDataWidth / DwordWidth;

    logic [DwordWidth-1:0] dword;

    assign resp_valid_o = rtrn_val_i;
    assign resp_id_o    = lookup_id_i;
    assign resp_pid_o   = lookup_pid_i;
    assign resp_error_o = (rtrn_type_i == l15_bridge_pkg::L15_ERR_RET);

    always_comb begin
        dword = '0;
        for (int w = 0; w < NumDwords; w++) begin
            dword = rtrn_data_i[w*DwordWidth +: DwordWidth];
            resp_data_o[w*DwordWidth +: DwordWidth] =
                SwapEndianness ? l15_bridge_pkg::swap_dword(dword) : dword;
        end
    end

    // Same event consumes the return and frees its thread id
    assign rtrn_ack_o = rtrn_val_i & resp_ready_i;
    assign free_tid_o = rtrn_val_i & resp_ready_i;

endmodule

//--- design/l15_req_fsm.sv
// Header-ack/ack handshake towards the L1.5 and per-thread id tables
// Request fields must stay stable until the final ack
`timescale 1ns/100ps
module l15_req_fsm #(
    parameter int unsigned TidWidth = 2,
    parameter int unsigned IdWidth  = 4,
    parameter int unsigned PidWidth = 3
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                req_valid_i,
    input  logic [IdWidth-1:0]  req_id_i,
    input  logic [PidWidth-1:0] req_pid_i,
    input  logic                tid_avail_i,
    input  logic [TidWidth-1:0] tid_i,
    input  logic                header_ack_i,
    input  logic                ack_i,
    output logic                l15_val_o,
    output logic                req_ready_o,
    input  logic [TidWidth-1:0] lookup_tid_i,
    output logic [IdWidth-1:0]  lookup_id_o,
    output logic [PidWidth-1:0] lookup_pid_o
);

    localparam int unsigned NumTids = 2 ** TidWidth;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HEADER_ACK,
        WAIT_ACK
    } state_e;

    state_e              state_q, state_d;
    logic [IdWidth-1:0]  id_tab  [NumTids];
    logic [PidWidth-1:0] pid_tab [NumTids];

    always_comb begin
        state_d     = state_q;
        l15_val_o   = 1'b0;
        req_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid_avail_i) begin
                    l15_val_o = 1'b1;
                    if (header_ack_i && ack_i) begin
                        req_ready_o = 1'b1;  // Both acks in the first cycle
                    end else if (header_ack_i) begin
                        state_d = WAIT_ACK;
                    end else begin
                        state_d = WAIT_HEADER_ACK;
                    end
                end
            end
            WAIT_HEADER_ACK: begin
                l15_val_o = 1'b1;
                if (header_ack_i && ack_i) begin
                    req_ready_o = 1'b1;
                    state_d     = IDLE;
                end else if (header_ack_i) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin  // Valid already dropped, fields still held
                if (ack_i) begin
                    req_ready_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Remember who issued the request on this thread id
    always_ff @(posedge clk_i) begin
        if (req_ready_o) begin
            id_tab[tid_i]  <= req_id_i;
            pid_tab[tid_i] <= req_pid_i;
        end
    end

    assign lookup_id_o  = id_tab[lookup_tid_i];
    assign lookup_pid_o = pid_tab[lookup_tid_i];

endmodule

//--- design/thread_id_pool.sv
// Free list of L1.5 thread ids, all ids free after reset in ascending order
// Pushes beyond the pool size are not expected
`timescale 1ns/100ps
module thread_id_pool #(
    parameter int unsigned TidWidth = 2
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                push_i,
    input  logic [TidWidth-1:0] push_tid_i,
    input  logic                pop_i,
    output logic                avail_o,
    output logic [TidWidth-1:0] tid_o
);

    localparam int unsigned NumTids = 2 ** TidWidth;

    logic [TidWidth-1:0] tid_mem [NumTids];
    logic [TidWidth-1:0] rd_ptr_q;
    logic [TidWidth-1:0] wr_ptr_q;
    logic [TidWidth:0]   count_q;
    logic                pop_ok;

    assign avail_o = (count_q != '0);
    assign tid_o   = tid_mem[rd_ptr_q];
    assign pop_ok  = pop_i & avail_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NumTids; i++) begin
                tid_mem[i] <= TidWidth'(i);  // Initial free list
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= (TidWidth+1)'(NumTids);
        end else begin
            if (push_i) begin
                tid_mem[wr_ptr_q] <= push_tid_i;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle or push with pop
            endcase
        end
    end

endmodule

//--- design/l15_req_encoder.sv
// Cache request to L1.5 request field translation, purely combinational
// Only the low dword of the write data is sent, masks of both halves are merged
`timescale 1ns/100ps
module l15_req_encoder #(
    parameter int unsigned MemDataWidth   = 128,
    parameter bit          SwapEndianness = 1,
    parameter logic [2:0]  IfillUncSize   = 3'd3
) (
    input  l15_bridge_pkg::req_kind_e               kind_i,
    input  logic [l15_bridge_pkg::PA_WIDTH-1:0]     addr_i,
    input  l15_bridge_pkg::req_size_t               size_i,
    input  logic                                    cacheable_i,
    input  logic [MemDataWidth-1:0]                 wdata_i,
    input  logic [MemDataWidth/8-1:0]               be_i,
    output l15_bridge_pkg::l15_rqtype_e             rqtype_o,
    output logic                                    nc_o,
    output logic [2:0]                              size_o,
    output logic [l15_bridge_pkg::PA_WIDTH-1:0]     address_o,
    output logic [63:0]                             data_o,
    output logic [7:0]                              l15_be_o
);

    logic [7:0]                          be_fold;
    l15_bridge_pkg::req_size_t           store_size;
    logic [l15_bridge_pkg::PA_WIDTH-1:0] store_addr;
    logic [63:0]                         dword;

    // Replicate a short value over the whole dword
    function automatic logic [63:0] replicate(input logic [63:0] d, input logic [2:0] off,
                                              input logic [2:0] sz);
        logic [63:0] r;
        case (sz)
            3'd0:    r = {8{d[{off, 3'b000} +: 8]}};
            3'd1:    r = {4{d[{off[2:1], 4'b0000} +: 16]}};
            3'd2:    r = {2{d[{off[2], 5'b00000} +: 32]}};
            default: r = d;
        endcase
        return r;
    endfunction

    assign be_fold = be_i[7:0] | be_i[MemDataWidth/8-1 -: 8];

    store_align i_store_align (
        .be_i     (be_fold),
        .addr_i   (addr_i),
        .size_o   (store_size),
        .offset_o (),          // Offset already folded into store_addr
        .addr_o   (store_addr)
    );

    always_comb begin
        case (kind_i)
            l15_bridge_pkg::REQ_IFILL: rqtype_o = l15_bridge_pkg::L15_IMISS_RQ;
            l15_bridge_pkg::REQ_STORE,
            l15_bridge_pkg::REQ_UNC_STORE: rqtype_o = l15_bridge_pkg::L15_STORE_RQ;
            default: rqtype_o = l15_bridge_pkg::L15_LOAD_RQ;
        endcase
    end

    assign nc_o = ~cacheable_i;

    always_comb begin
        if (kind_i == l15_bridge_pkg::REQ_IFILL) begin
            size_o = cacheable_i ? l15_bridge_pkg::SIZE_IFILL_LINE : IfillUncSize;
        end else if (kind_i == l15_bridge_pkg::REQ_STORE) begin
            size_o = store_size + 3'd1;
        end else begin
            size_o = size_i + 3'd1;
        end
    end

    // Stores are aligned to their own size
    assign address_o = (kind_i == l15_bridge_pkg::REQ_STORE) ? store_addr : addr_i;

    assign dword = (kind_i == l15_bridge_pkg::REQ_UNC_STORE)
                   ? replicate(wdata_i[63:0], addr_i[2:0], size_i) : wdata_i[63:0];

    assign data_o = SwapEndianness ? l15_bridge_pkg::swap_dword(dword) : dword;

    assign l15_be_o = {<<{be_fold}};  // L1.5 numbers bytes from the MSB

endmodule

//--- design/store_align.sv
// Store size and alignment from an 8-bit byte mask
// Only 1, 2 or 4 set bits give a sub-dword size, anything else is treated as 8 bytes
`timescale 1ns/100ps
module store_align (
    input  logic [l15_bridge_pkg::DWORD_BYTES-1:0] be_i,
    input  logic [l15_bridge_pkg::PA_WIDTH-1:0]    addr_i,
    output l15_bridge_pkg::req_size_t              size_o,
    output logic [2:0]                             offset_o,
    output logic [l15_bridge_pkg::PA_WIDTH-1:0]    addr_o
);

    logic [3:0] num_ones;
    logic [2:0] top_bit;  // Highest set mask bit

    always_comb begin
        num_ones = '0;
        top_bit  = '0;
        for (int i = 0; i < l15_bridge_pkg::DWORD_BYTES; i++) begin
            num_ones = num_ones + 4'(be_i[i]);
            if (be_i[i]) begin
                top_bit = 3'(i);
            end
        end
    end

    always_comb begin
        case (num_ones)
            4'd1: begin
                size_o   = 3'd0;
                offset_o = top_bit;
            end
            4'd2: begin
                size_o   = 3'd1;
                offset_o = top_bit - 3'd1;
            end
            4'd4: begin
                size_o   = 3'd2;
                offset_o = top_bit - 3'd3;
            end
            default: begin  // Full dword or irregular mask
                size_o   = 3'd3;
                offset_o = '0;
            end
        endcase
    end

    // Low bits replaced by the offset only for sub-dword stores
    assign addr_o = (size_o == 3'd3) ? addr_i
                                     : {addr_i[l15_bridge_pkg::PA_WIDTH-1:3], offset_o};

endmodule

//--- design/l15_bridge_pkg.sv
// Shared widths and L1.5 codes for the cache to L1.5 bridge
// Type codes follow the OpenPiton L1.5 encoding, atomics not included
package l15_bridge_pkg;

    localparam int unsigned PA_WIDTH    = 40;
    localparam int unsigned DWORD_BYTES = 8;

    // Size as log2 of the byte count
    typedef logic [2:0] req_size_t;

    localparam logic [2:0] SIZE_IFILL_LINE = 3'd6;  // 32-byte line fill

    typedef enum logic [2:0] {
        REQ_IFILL     = 3'd0,
        REQ_LOAD      = 3'd1,
        REQ_STORE     = 3'd2,
        REQ_UNC_LOAD  = 3'd3,
        REQ_UNC_STORE = 3'd4
    } req_kind_e;

    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001,
        L15_IMISS_RQ = 5'b10000
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        L15_LOAD_RET  = 4'b0000,
        L15_IFILL_RET = 4'b0001,
        L15_ERR_RET   = 4'b0011,
        L15_STORE_ACK = 4'b0100
    } l15_rtrntype_e;

    // Byte order reversal inside one dword
    function automatic logic [DWORD_BYTES*8-1:0] swap_dword(input logic [DWORD_BYTES*8-1:0] d);
        logic [DWORD_BYTES*8-1:0] s;
        for (int b = 0; b < DWORD_BYTES; b++) begin
            s[b*8 +: 8] = d[(DWORD_BYTES-1-b)*8 +: 8];
        end
        return s;
    endfunction

endpackage
